//--- boot_stream/boot_stream_in.sv
// Boot stream input: word handshake, byte swap, byte FIFO, paced release and download tracking
`timescale 1ns/1ps

module boot_stream_in import loader_pkg::*; (
	input  logic       clk,
	input  logic       host_reset_loader,
	input  boot_word_t bootdata_i,
	input  logic       bootdata_req_i,
	input  logic       download_end_i,
	output logic       bootdata_ack_o,
	output rom_byte_t  byte_o,
	output logic       byte_stb_o,
	output logic       downloading_o
);

	typedef enum logic {ACC_IDLE, ACC_HOLD} acc_state_t;

	acc_state_t            acc_state;
	rom_byte_t             fifo_mem [FIFO_DEPTH];
	logic [FIFO_AW-1:0]    wr_ptr;
	logic [FIFO_AW-1:0]    rd_ptr;
	logic [FIFO_CNT_W-1:0] fifo_count;
	logic [PACE_W-1:0]     pace_cnt;
	logic                  end_seen;    // download_end_i has been seen
	boot_word_t            swapped;
	logic                  room;
	logic                  push;
	logic                  pop;
	logic                  pace_wrap;

	// Byte order reversed; top of swapped is the lowest host byte
	assign swapped = {bootdata_i[7:0], bootdata_i[15:8], bootdata_i[23:16], bootdata_i[31:24]};

	assign room = (fifo_count <= FIFO_CNT_W'(FIFO_DEPTH - WORD_BYTES));    // Space for a word
	assign push = (acc_state == ACC_IDLE) && bootdata_req_i && room;

	// ------------------------------------------------------------
	// Accept machine
	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (host_reset_loader) begin
			acc_state      <= ACC_IDLE;
			bootdata_ack_o <= 1'b0;
		end else begin
			case (acc_state)
			ACC_IDLE: begin
				bootdata_ack_o <= push;    // Word taken on this edge
				if (push)
					acc_state <= ACC_HOLD;
			end
			ACC_HOLD: begin
				// Request ignored here, host drops it after ack
				bootdata_ack_o <= 1'b0;
				acc_state      <= ACC_IDLE;
			end
			default: acc_state <= ACC_IDLE;
			endcase
		end
	end

	// Four bytes per push, lowest host byte first
	always_ff @(posedge clk) begin
		if (push) begin
			for (int k = 0; k < WORD_BYTES; k++)
				fifo_mem[wr_ptr + FIFO_AW'(k)] <= swapped[BOOT_WORD_W-1-ROM_BYTE_W*k -: ROM_BYTE_W];
		end
	end

	// ------------------------------------------------------------
	// Paced read side
	// ------------------------------------------------------------
	assign pace_wrap  = (pace_cnt == PACE_W'(BYTE_PERIOD - 1));
	assign pop        = pace_wrap && (fifo_count != '0);
	assign byte_stb_o = pop;
	assign byte_o     = fifo_mem[rd_ptr];    // Valid in the strobe clock

	always_ff @(posedge clk) begin
		if (host_reset_loader) begin
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			fifo_count <= '0;
			pace_cnt   <= '0;
		end else begin
			pace_cnt <= pace_wrap ? '0 : pace_cnt + 1'b1;
			if (push)
				wr_ptr <= wr_ptr + FIFO_AW'(WORD_BYTES);
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			fifo_count <= fifo_count
				+ (push ? FIFO_CNT_W'(WORD_BYTES) : FIFO_CNT_W'(0))
				- (pop ? FIFO_CNT_W'(1) : FIFO_CNT_W'(0));
		end
	end

	// Download ends once the host says so and the FIFO has drained
	always_ff @(posedge clk) begin
		if (host_reset_loader) begin
			end_seen      <= 1'b0;
			downloading_o <= 1'b1;
		end else begin
			if (download_end_i)
				end_seen <= 1'b1;
			if (end_seen && (fifo_count == '0))
				downloading_o <= 1'b0;
		end
	end

	// Count stays within the FIFO after a push and agrees with the pointer distance
	a_no_overflow: assert property (@(posedge clk) disable iff (host_reset_loader)
		push |=> (fifo_count <= FIFO_CNT_W'(FIFO_DEPTH))
			&& (fifo_count[FIFO_AW-1:0] == FIFO_AW'(wr_ptr - rd_ptr)));

	// Bytes only leave while the pointers hold unread data, never after the download closed
	a_no_underflow: assert property (@(posedge clk) disable iff (host_reset_loader)
		byte_stb_o |-> ((rd_ptr != wr_ptr) || (fifo_count == FIFO_CNT_W'(FIFO_DEPTH)))
			&& downloading_o);

endmodule

//--- common/loader_pkg.sv
// Loader package: shared widths, memory map, header magic, pacing and the mapper flag word
package loader_pkg;

	// ------------------------------------------------------------
	// Widths and basic types
	// ------------------------------------------------------------
	localparam int MEM_ADDR_W  = 22;
	localparam int ROM_BYTE_W  = 8;
	localparam int BOOT_WORD_W = 32;
	localparam int WORD_BYTES  = BOOT_WORD_W / ROM_BYTE_W;    // Bytes per host word

	typedef logic [MEM_ADDR_W-1:0]  mem_addr_t;
	typedef logic [ROM_BYTE_W-1:0]  rom_byte_t;
	typedef logic [BOOT_WORD_W-1:0] boot_word_t;
	typedef logic [7:0]             file_type_t;

	localparam file_type_t FT_BIOS = 8'h02;    // FDS BIOS image
	localparam file_type_t FT_FDS  = 8'h03;    // FDS ROM, header optional

	// ------------------------------------------------------------
	// Memory map
	// ------------------------------------------------------------
	localparam mem_addr_t PRG_BASE     = 22'h000000;
	localparam mem_addr_t CHR_BASE     = 22'h200000;
	localparam mem_addr_t FDS_BASE     = 22'h010010;    // FDS image, header skipped
	localparam mem_addr_t FDS_RAW_BASE = 22'h010020;    // FDS image without header
	localparam mem_addr_t BIOS_BASE    = 22'h000010;

	// iNES header layout
	localparam int HEADER_BYTES   = 16;
	localparam int HDR_CNT_W      = $clog2(HEADER_BYTES);
	localparam int PRG_PAGE_SHIFT = 14;    // 16 KB pages
	localparam int CHR_PAGE_SHIFT = 13;    // 8 KB pages

	localparam logic [31:0] NES_MAGIC = 32'h4E45531A;    // "NES" then 1A
	localparam logic [31:0] FDS_MAGIC = 32'h4644531A;    // "FDS" then 1A

	// Header bytes forced once an FDS or BIOS stream ends
	localparam rom_byte_t FDS_HDR_PRG = 8'hFF;    // No PRG masking
	localparam rom_byte_t FDS_HDR_B6  = 8'h40;    // Mapper low nibble 4
	localparam rom_byte_t FDS_HDR_B7  = 8'h10;    // Mapper high nibble 1

	// ------------------------------------------------------------
	// Pacing and buffering
	// ------------------------------------------------------------
	localparam int BYTE_PERIOD = 16;    // Clocks between byte releases
	localparam int PACE_W      = $clog2(BYTE_PERIOD);
	localparam int SLOT_PERIOD = 4;     // One memory slot every fourth clock
	localparam int SLOT_W      = $clog2(SLOT_PERIOD);
	localparam int FIFO_DEPTH  = 16;
	localparam int FIFO_AW     = $clog2(FIFO_DEPTH);
	localparam int FIFO_CNT_W  = $clog2(FIFO_DEPTH + 1);    // Holds 0 to FIFO_DEPTH

	// Mapper flag word as seen by the console core
	typedef struct packed {
		logic [6:0] reserved;     // Always zero
		logic [7:0] submapper;    // iNES 2.0 only
		logic       four_screen;
		logic       chr_ram;
		logic       mirroring;
		logic [2:0] chr_size;
		logic [2:0] prg_size;
		logic [7:0] mapper;
	} mapper_flags_t;

endpackage

//--- common/loader_write_if.sv
// Loader write interface: byte writes plus done, error and mapper flags toward the output side
`timescale 1ns/1ps

interface loader_write_if import loader_pkg::*; ();

	mem_addr_t     addr;     // Target byte address
	rom_byte_t     data;     // Byte to write
	logic          wr;       // One clock per byte
	logic          done;     // Level, stays high once set
	logic          error;    // Valid with done
	mapper_flags_t flags;    // Meaningful once done

	// Parser side
	modport loader (
		output addr,
		output data,
		output wr,
		output done,
		output error,
		output flags
	);

	// Memory side
	modport stager (
		input addr,
		input data,
		input wr,
		input done,
		input error,
		input flags
	);

endinterface

//--- compile.f
+incdir+verification
common/loader_pkg.sv
common/loader_write_if.sv
boot_stream/boot_stream_in.sv
loader/ines_loader.sv
verilog/mem_write_stager.sv
verilog/rom_loader_top.sv
verification/tb_rom_loader.sv

//--- loader/ines_loader.sv
// iNES and FDS loader: header parse, signature check, PRG/CHR/stream addressing and mapper flags
`timescale 1ns/1ps

module ines_loader import loader_pkg::*; (
	input  logic           clk,
	input  logic           host_reset_loader,
	input  file_type_t     filetype_i,
	input  rom_byte_t      byte_i,
	input  logic           byte_stb_i,
	input  logic           downloading_i,
	loader_write_if.loader wr_o
);

	typedef enum logic [2:0] {ST_HEADER, ST_PRG, ST_CHR, ST_ERROR, ST_STREAM} state_t;

	state_t               state;
	rom_byte_t            hdr [HEADER_BYTES];    // Raw iNES header
	logic [HDR_CNT_W-1:0] hdr_cnt;
	mem_addr_t            addr_q;
	mem_addr_t            bytes_left;            // Remaining PRG or CHR bytes
	logic                 done_q;
	logic                 error_q;
	logic                 wr;
	logic                 hdr_last;
	logic                 nes_magic;
	logic                 fds_magic;
	logic                 is_nes20;
	logic                 tail_nonzero;
	logic                 is_dirty;
	mapper_flags_t        flags;

	// Page count to size code, <=1 gives 0, doubling up to 7
	function automatic logic [2:0] size_code(input rom_byte_t pages);
		logic [2:0] code;
		code = 3'd7;
		for (int i = 6; i >= 0; i--) begin
			if ({1'b0, pages} <= (9'd1 << i))
				code = 3'(i);
		end
		return code;
	endfunction

	assign hdr_last  = (hdr_cnt == HDR_CNT_W'(HEADER_BYTES - 1));
	assign nes_magic = ({hdr[0], hdr[1], hdr[2], hdr[3]} == NES_MAGIC);
	assign fds_magic = ({hdr[0], hdr[1], hdr[2], hdr[3]} == FDS_MAGIC);

	// ------------------------------------------------------------
	// Write qualifier, same clock as the byte strobe
	// ------------------------------------------------------------
	always_comb begin
		case (state)
		ST_HEADER, ST_STREAM: wr = byte_stb_i && downloading_i;
		ST_PRG, ST_CHR:       wr = byte_stb_i && (bytes_left != '0);
		default:              wr = 1'b0;    // Error state writes nothing
		endcase
	end

	// ------------------------------------------------------------
	// Main FSM
	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (host_reset_loader) begin
			state      <= ST_HEADER;
			hdr_cnt    <= '0;
			addr_q     <= (filetype_i == FT_FDS) ? FDS_BASE : PRG_BASE;
			bytes_left <= '0;
			done_q     <= 1'b0;
			error_q    <= 1'b0;
		end else begin
			case (state)
			ST_HEADER: if (byte_stb_i) begin
				hdr_cnt <= hdr_cnt + 1'b1;
				addr_q  <= addr_q + 1'b1;
				if (hdr_last) begin
					// Trainers are not supported
					if (nes_magic && !hdr[6][2]) begin
						state      <= ST_PRG;
						addr_q     <= PRG_BASE;
						bytes_left <= mem_addr_t'(hdr[4]) << PRG_PAGE_SHIFT;
					end else if (fds_magic) begin
						state  <= ST_STREAM;
						addr_q <= FDS_BASE;
					end else if (filetype_i == FT_BIOS) begin
						state  <= ST_STREAM;
						addr_q <= BIOS_BASE;
					end else if (filetype_i == FT_FDS) begin
						state  <= ST_STREAM;    // Headerless FDS image
						addr_q <= FDS_RAW_BASE;
					end else begin
						state <= ST_ERROR;
					end
				end
			end
			ST_PRG, ST_CHR: begin
				if (bytes_left != '0) begin
					if (byte_stb_i) begin
						bytes_left <= bytes_left - 1'b1;
						addr_q     <= addr_q + 1'b1;
					end
				end else if (state == ST_PRG) begin
					state      <= ST_CHR;
					addr_q     <= CHR_BASE;
					bytes_left <= mem_addr_t'(hdr[5]) << CHR_PAGE_SHIFT;    // Zero means CHR-RAM
				end else begin
					done_q <= 1'b1;
				end
			end
			ST_ERROR: begin
				done_q  <= 1'b1;
				error_q <= 1'b1;
			end
			ST_STREAM: begin
				if (downloading_i) begin
					if (byte_stb_i)
						addr_q <= addr_q + 1'b1;
				end else begin
					done_q <= 1'b1;
				end
			end
			default: state <= ST_ERROR;
			endcase
		end
	end

	// Header store, FDS values forced when the stream closes
	always_ff @(posedge clk) begin
		if ((state == ST_HEADER) && byte_stb_i) begin
			hdr[hdr_cnt] <= byte_i;
		end else if ((state == ST_STREAM) && !downloading_i && !done_q) begin
			hdr[4] <= FDS_HDR_PRG;
			hdr[5] <= '0;
			hdr[6] <= FDS_HDR_B6;
			hdr[7] <= FDS_HDR_B7;
			for (int i = 8; i < HEADER_BYTES; i++)
				hdr[i] <= '0;
		end
	end

	// ------------------------------------------------------------
	// Mapper flags
	// ------------------------------------------------------------
	assign is_nes20 = (hdr[7][3:2] == 2'b10);

	// Junk in the tail marks an old dirty iNES 1.0 header
	always_comb begin
		tail_nonzero = (hdr[9][7:1] != '0);
		for (int i = 10; i < HEADER_BYTES; i++)
			tail_nonzero = tail_nonzero | (hdr[i] != '0);
	end

	assign is_dirty = !is_nes20 && tail_nonzero;

	always_comb begin
		flags             = '0;
		flags.submapper   = is_nes20 ? hdr[8] : 8'h00;
		flags.four_screen = hdr[6][3];
		flags.chr_ram     = (hdr[5] == '0);
		flags.mirroring   = hdr[6][0];
		flags.chr_size    = size_code(hdr[5]);
		flags.prg_size    = size_code(hdr[4]);
		flags.mapper      = {is_dirty ? 4'h0 : hdr[7][7:4], hdr[6][7:4]};    // Upper nibble dropped
	end

	assign wr_o.addr  = addr_q;
	assign wr_o.data  = byte_i;
	assign wr_o.wr    = wr;
	assign wr_o.done  = done_q;
	assign wr_o.error = error_q;
	assign wr_o.flags = flags;

	// Writes only in the data states, never after done
	a_wr_state: assert property (@(posedge clk) disable iff (host_reset_loader)
		wr |-> (state inside {ST_HEADER, ST_PRG, ST_CHR, ST_STREAM}) && !done_q);

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Build the ROM loader testbench with Verilator, run it and look for the pass line
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	-f compile.f \
	--top-module tb_rom_loader \
	-o sim_rom_loader

out=$(./obj_dir/sim_rom_loader || true)
echo "$out"

if echo "$out" | grep -q '^\*\* PASS \*\*$'; then
	echo "Simulation passed"
	exit 0
fi

echo "Simulation failed"
exit 1

//--- verification/rom_tests.txt
# type, header bytes 0..15 (hex), payload length (dec), flags, error, prg/chr/stream base (hex)
# Bases that a mode does not use are zero
01 4E 45 53 1A 01 01 41 10 00 00 00 00 00 00 00 00 24576 00004014 0 000000 200000 000000
01 4E 45 53 1A 01 00 28 38 05 00 00 00 00 00 00 00 16384 000B8032 0 000000 200000 000000
01 4E 45 53 1A 02 01 11 70 00 00 00 00 44 00 00 00 40960 00004101 0 000000 200000 000000
03 46 44 53 1A 00 00 00 00 00 00 00 00 00 00 00 00 40 00008714 0 000000 000000 010010
02 00 11 22 33 44 55 66 77 88 99 AA BB CC DD EE FF 36 00008714 0 000000 000000 000010
03 12 34 56 78 9A BC DE F0 0F ED CB A9 87 65 43 21 20 00008714 0 000000 000000 010020
00 42 41 44 21 00 00 00 00 00 00 00 00 00 00 00 00 0 00008000 1 000000 000000 000000
00 4E 45 53 1A 01 01 04 00 00 00 00 00 00 00 00 00 0 00000000 1 000000 000000 000000

//--- verification/tb_checks.svh
// Testbench helpers: typed compare tasks for loader results and the payload LCG
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// Numerical Recipes LCG constants
function automatic logic [31:0] lcg_next(input logic [31:0] state);
	return state * 32'd1664525 + 32'd1013904223;
endfunction

// ------------------------------------------------------------
// Compare tasks, one per result type
// ------------------------------------------------------------
task automatic check_addr(input mem_addr_t got, input mem_addr_t exp, input string what);
	if (got !== exp) begin
		$display("MISMATCH @ %0t ns: %s got %h expected %h", $time, what, got, exp);
		fail_run();
	end
endtask

task automatic check_byte(input rom_byte_t got, input rom_byte_t exp, input string what);
	if (got !== exp) begin
		$display("MISMATCH @ %0t ns: %s got %h expected %h", $time, what, got, exp);
		fail_run();
	end
endtask

task automatic check_flags(input mapper_flags_t got, input mapper_flags_t exp,
		input string what);
	if (got !== exp) begin
		$display("MISMATCH @ %0t ns: %s got %h expected %h", $time, what, got, exp);
		fail_run();
	end
endtask

task automatic check_bit(input logic got, input logic exp, input string what);
	if (got !== exp) begin
		$display("MISMATCH @ %0t ns: %s got %b expected %b", $time, what, got, exp);
		fail_run();
	end
endtask

// Handshake counts
task automatic check_count(input int got, input int exp, input string what);
	if (got != exp) begin
		$display("MISMATCH @ %0t ns: %s got %0d expected %0d", $time, what, got, exp);
		fail_run();
	end
endtask

`endif

//--- verification/tb_rom_loader.sv
// ROM loader testbench: file driven iNES/FDS loads with a write scoreboard and watchdog
`timescale 1ns/1ps

module tb_rom_loader import loader_pkg::*; ();

	localparam int    CLK_HALF       = 10;
	localparam int    RESET_CYCLES   = 5;
	localparam int    MAX_TESTS      = 16;
	localparam int    ERR_TAIL_BYTES = 8;    // Trailing bytes after a rejected header
	localparam int    QUIET_CYCLES   = (FIFO_DEPTH + 1) * BYTE_PERIOD + 2 * SLOT_PERIOD;
	localparam string TEST_FILE      = "verification/rom_tests.txt";

	logic          clk = 1'b0;
	logic          host_reset_loader;
	boot_word_t    bootdata_i;
	logic          bootdata_req_i;
	logic          bootdata_ack_o;
	file_type_t    filetype_i;
	logic          download_end_i;
	mem_addr_t     mem_addr_o;
	rom_byte_t     mem_data_o;
	logic          mem_write_o;
	mapper_flags_t mapper_flags_o;
	logic          load_done_o;
	logic          load_error_o;

	// Test table from the data file
	int            num_tests;
	file_type_t    t_type  [MAX_TESTS];
	rom_byte_t     t_hdr   [MAX_TESTS][HEADER_BYTES];
	int            t_len   [MAX_TESTS];
	mapper_flags_t t_flags [MAX_TESTS];
	logic          t_err   [MAX_TESTS];
	mem_addr_t     t_prg   [MAX_TESTS];
	mem_addr_t     t_chr   [MAX_TESTS];
	mem_addr_t     t_str   [MAX_TESTS];

	mem_addr_t   exp_addr_q [$];    // Scoreboard
	rom_byte_t   exp_data_q [$];
	logic [31:0] lcg_state = 32'h66aa6bdc;
	int          ack_count;
	logic        ack_prev;
	realtime     wd_limit;
	logic        wd_armed = 1'b0;

	rom_loader_top rom_loader_top_inst (
		.clk               (clk),
		.host_reset_loader (host_reset_loader),
		.bootdata_i        (bootdata_i),
		.bootdata_req_i    (bootdata_req_i),
		.bootdata_ack_o    (bootdata_ack_o),
		.filetype_i        (filetype_i),
		.download_end_i    (download_end_i),
		.mem_addr_o        (mem_addr_o),
		.mem_data_o        (mem_data_o),
		.mem_write_o       (mem_write_o),
		.mapper_flags_o    (mapper_flags_o),
		.load_done_o       (load_done_o),
		.load_error_o      (load_error_o)
	);

	always #CLK_HALF clk = ~clk;    // 20 ns period

	task automatic fail_run();
		$display("** FAIL **");
		$fatal(1, "stopped at first error");
	endtask

	`include "tb_checks.svh"

	// ------------------------------------------------------------
	// Monitor: ack pulses and memory writes, sampled mid cycle
	// ------------------------------------------------------------
	always @(negedge clk) begin
		if (!host_reset_loader) begin
			if (bootdata_ack_o && ack_prev) begin
				$display("ERROR @ %0t ns: ack stayed high for two clocks", $time);
				fail_run();
			end
			if (bootdata_ack_o)
				ack_count++;
			if (mem_write_o) begin
				if (exp_addr_q.size() == 0) begin
					$display("ERROR @ %0t ns: memory write %h not expected", $time, mem_addr_o);
					fail_run();
				end
				check_addr(mem_addr_o, exp_addr_q.pop_front(), "write address");
				check_byte(mem_data_o, exp_data_q.pop_front(), "write data");
			end
		end
		ack_prev = bootdata_ack_o;
	end

	// Reads the table, one test per non comment line
	task automatic read_tests();
		int          fd;
		int          n;
		string       line;
		logic [31:0] f [23];
		fd = $fopen(TEST_FILE, "r");
		if (fd == 0) begin
			$display("ERROR: cannot open %s", TEST_FILE);
			fail_run();
		end
		num_tests = 0;
		while (!$feof(fd) && num_tests < MAX_TESTS) begin
			if ($fgets(line, fd) == 0)
				break;
			if (line.len() < 2 || line.substr(0, 0) == "#")
				continue;
			n = $sscanf(line,
				"%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %d %h %h %h %h %h",
				f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10], f[11],
				f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19], f[20], f[21], f[22]);
			if (n != 23) begin
				$display("ERROR: malformed test line: %s", line);
				fail_run();
			end
			t_type[num_tests] = f[0][7:0];
			for (int k = 0; k < HEADER_BYTES; k++)
				t_hdr[num_tests][k] = f[k+1][7:0];
			t_len[num_tests]   = int'(f[17]);
			t_flags[num_tests] = f[18];
			t_err[num_tests]   = f[19][0];
			t_prg[num_tests]   = f[20][MEM_ADDR_W-1:0];
			t_chr[num_tests]   = f[21][MEM_ADDR_W-1:0];
			t_str[num_tests]   = f[22][MEM_ADDR_W-1:0];
			num_tests++;
		end
		$fclose(fd);
	endtask

	// One word with the req/ack rule
	task automatic send_word(input boot_word_t w);
		@(negedge clk);
		bootdata_i     = w;
		bootdata_req_i = 1'b1;
		do
			@(negedge clk);
		while (!bootdata_ack_o);
		bootdata_req_i = 1'b0;
	endtask

	task automatic run_test(input int i);
		rom_byte_t bytes [$];
		mem_addr_t hdr_base;
		int        prg_len;
		int        chr_len;
		int        pay_len;
		logic      nes;
		boot_word_t w;
		filetype_i     = t_type[i];
		download_end_i = 1'b0;
		host_reset_loader = 1'b1;
		repeat (RESET_CYCLES) @(negedge clk);
		check_bit(bootdata_ack_o, 1'b0, "ack in reset");
		check_bit(mem_write_o, 1'b0, "write in reset");
		check_bit(load_done_o, 1'b0, "done in reset");
		check_bit(load_error_o, 1'b0, "error in reset");
		exp_addr_q.delete();
		exp_data_q.delete();
		ack_count = 0;
		host_reset_loader = 1'b0;

		// Header goes out first, at 0 or at the FDS base for file type 3
		hdr_base = (t_type[i] == 8'h03) ? 22'h010010 : 22'h000000;
		for (int k = 0; k < HEADER_BYTES; k++) begin
			bytes.push_back(t_hdr[i][k]);
			exp_addr_q.push_back(hdr_base + mem_addr_t'(k));
			exp_data_q.push_back(t_hdr[i][k]);
		end
		nes = ({t_hdr[i][0], t_hdr[i][1], t_hdr[i][2], t_hdr[i][3]} == 32'h4E45531A)
			&& !t_hdr[i][6][2];
		prg_len = int'(t_hdr[i][4]) * 16384;
		chr_len = int'(t_hdr[i][5]) * 8192;
		// A rejected header is followed by bytes that must never reach memory
		pay_len = t_err[i] ? t_len[i] + ERR_TAIL_BYTES : t_len[i];
		for (int j = 0; j < pay_len; j++) begin
			lcg_state = lcg_next(lcg_state);
			bytes.push_back(lcg_state[23:16]);
			if (!t_err[i]) begin
				if (!nes)
					exp_addr_q.push_back(t_str[i] + mem_addr_t'(j));
				else if (j < prg_len)
					exp_addr_q.push_back(t_prg[i] + mem_addr_t'(j));
				else
					exp_addr_q.push_back(t_chr[i] + mem_addr_t'(j - prg_len));
				exp_data_q.push_back(lcg_state[23:16]);
			end
		end
		if (nes && !t_err[i] && (prg_len + chr_len != t_len[i])) begin
			$display("ERROR: test %0d payload length does not match header", i);
			fail_run();
		end

		// Lowest byte first in each word
		for (int j = 0; j < bytes.size(); j += 4) begin
			w = {bytes[j+3], bytes[j+2], bytes[j+1], bytes[j]};
			send_word(w);
			if (!nes && !t_err[i])
				check_bit(load_done_o, 1'b0, "stream done before download end");
		end
		@(negedge clk);
		download_end_i = 1'b1;

		while (!load_done_o)
			@(negedge clk);
		while (exp_addr_q.size() != 0)
			@(negedge clk);
		repeat (QUIET_CYCLES) @(negedge clk);    // FIFO drains, stray writes show up

		check_flags(mapper_flags_o, t_flags[i], "mapper flags");
		check_bit(load_error_o, t_err[i], "load error");
		check_bit(load_done_o, 1'b1, "load done");
		check_count(ack_count, bytes.size() / 4, "ack count");
		$display("test %0d done, type %0d, %0d payload bytes", i, t_type[i], pay_len);
	endtask

	// ------------------------------------------------------------
	// Watchdog, sized from the total byte count
	// ------------------------------------------------------------
	initial begin
		wait (wd_armed);
		#(wd_limit);
		$display("ERROR @ %0t ns: run timed out waiting for the DUT", $time);
		fail_run();
	end

	initial begin
		int total_bytes;
		host_reset_loader = 1'b1;
		bootdata_i        = '0;
		bootdata_req_i    = 1'b0;
		filetype_i        = '0;
		download_end_i    = 1'b0;
		ack_prev          = 1'b0;
		read_tests();
		total_bytes = 0;
		for (int i = 0; i < num_tests; i++)
			total_bytes += HEADER_BYTES + t_len[i] + (t_err[i] ? ERR_TAIL_BYTES : 0);
		wd_limit = real'(total_bytes) * BYTE_PERIOD * 2 * (2 * CLK_HALF) + 100000.0;
		wd_armed = 1'b1;
		for (int i = 0; i < num_tests; i++)
			run_test(i);
		$display("** PASS **");
		$finish;
	end

endmodule

//--- verilog/mem_write_stager.sv
// Memory write stager: holds each loader write for the next memory slot and latches mapper flags
`timescale 1ns/1ps

module mem_write_stager import loader_pkg::*; (
	input  logic           clk,
	input  logic           host_reset_loader,
	loader_write_if.stager wr_i,
	output mem_addr_t      mem_addr_o,
	output rom_byte_t      mem_data_o,
	output logic           mem_write_o,
	output mapper_flags_t  mapper_flags_o,
	output logic           load_done_o,
	output logic           load_error_o
);

	logic [SLOT_W-1:0] slot_cnt;    // Free running slot phase
	logic              slot_now;
	logic              pending;     // Write waiting for its slot
	mem_addr_t         addr_q;
	rom_byte_t         data_q;
	mapper_flags_t     flags_q;

	assign slot_now = (slot_cnt == SLOT_W'(SLOT_PERIOD - 1));

	// ------------------------------------------------------------
	// Slot alignment
	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (host_reset_loader) begin
			slot_cnt <= '0;
			pending  <= 1'b0;
		end else begin
			slot_cnt <= slot_now ? '0 : slot_cnt + 1'b1;
			if (wr_i.wr)
				pending <= 1'b1;
			else if (slot_now)
				pending <= 1'b0;    // Issued this clock
		end
	end

	// Captured payload
	always_ff @(posedge clk) begin
		if (wr_i.wr) begin
			addr_q <= wr_i.addr;
			data_q <= wr_i.data;
		end
		if (wr_i.done)
			flags_q <= wr_i.flags;    // Follows done by one clock
	end

	assign mem_write_o    = pending && slot_now;
	assign mem_addr_o     = addr_q;
	assign mem_data_o     = data_q;
	assign mapper_flags_o = flags_q;
	assign load_done_o    = wr_i.done;
	assign load_error_o   = wr_i.error;

	// Byte pacing upstream keeps one write per slot window
	a_no_overrun: assert property (@(posedge clk) disable iff (host_reset_loader)
		wr_i.wr |-> !pending);

endmodule

//--- verilog/rom_loader_top.sv
// ROM loader top: boot word input, iNES/FDS loader and memory write stager
`timescale 1ns/1ps

module rom_loader_top import loader_pkg::*; (
	input  logic          clk,
	input  logic          host_reset_loader,
	// Host boot stream
	input  boot_word_t    bootdata_i,
	input  logic          bootdata_req_i,
	output logic          bootdata_ack_o,
	input  file_type_t    filetype_i,
	input  logic          download_end_i,
	// Memory write port
	output mem_addr_t     mem_addr_o,
	output rom_byte_t     mem_data_o,
	output logic          mem_write_o,
	// Load result
	output mapper_flags_t mapper_flags_o,
	output logic          load_done_o,
	output logic          load_error_o
);

	rom_byte_t loader_byte;
	logic      loader_byte_stb;
	logic      downloading;

	loader_write_if ldr_wr_if ();

	// ------------------------------------------------------------
	// Input side
	// ------------------------------------------------------------
	boot_stream_in boot_stream_in_inst (
		.clk               (clk),
		.host_reset_loader (host_reset_loader),
		.bootdata_i        (bootdata_i),
		.bootdata_req_i    (bootdata_req_i),
		.download_end_i    (download_end_i),
		.bootdata_ack_o    (bootdata_ack_o),
		.byte_o            (loader_byte),
		.byte_stb_o        (loader_byte_stb),
		.downloading_o     (downloading)
	);

	// Header parse and addressing
	ines_loader ines_loader_inst (
		.clk               (clk),
		.host_reset_loader (host_reset_loader),
		.filetype_i        (filetype_i),
		.byte_i            (loader_byte),
		.byte_stb_i        (loader_byte_stb),
		.downloading_i     (downloading),
		.wr_o              (ldr_wr_if.loader)
	);

	// Output side
	mem_write_stager mem_write_stager_inst (
		.clk               (clk),
		.host_reset_loader (host_reset_loader),
		.wr_i              (ldr_wr_if.stager),
		.mem_addr_o        (mem_addr_o),
		.mem_data_o        (mem_data_o),
		.mem_write_o       (mem_write_o),
		.mapper_flags_o    (mapper_flags_o),
		.load_done_o       (load_done_o),
		.load_error_o      (load_error_o)
	);

endmodule
